// File: rtl/lut_config.svh
// ################################################
// Sizes for the lookup table and its credit links
// Queue and credit depths must be powers of two
// ################################################
`ifndef LUT_CONFIG_SVH
`define LUT_CONFIG_SVH

// Table index width, 256 entries
`define LUT_ADDR_W 8

// One SRAM half, two halves per entry
`define LUT_HALF_W 42

// Ingress queue depth and client start credits
`define LUT_REQ_DEPTH 4

// Egress start credits and buffer depth
`define LUT_RSP_CREDITS 4
`define LUT_RSP_DEPTH 4

`endif

// File: rtl/mem_pkg.sv
// ################################################
// SRAM-side types, entry is two equal halves
// ################################################
`include "lut_config.svh"

package mem_pkg;

  // Table index
  typedef logic [`LUT_ADDR_W-1:0] addr_t;

  // One half of an entry
  typedef logic [`LUT_HALF_W-1:0] half_t;

  // Full entry, low half in the low bits
  typedef logic [2*`LUT_HALF_W-1:0] word_t;

  // Bit 0 low half, bit 1 high half
  typedef logic [1:0] half_mask_t;

endpackage

// File: rtl/link_pkg.sv
// ################################################
// Client link payloads, request 95b, response 84b
// ################################################

package link_pkg;

  // Request opcode
  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_e;

  // One request beat
  typedef struct packed {
    op_e                 op;
    mem_pkg::addr_t      index;
    // Write data, ignored on reads
    mem_pkg::word_t      data;
    // Halves to write, ignored on reads
    mem_pkg::half_mask_t mask;
  } lut_req_t;

  // One response beat, full entry read back
  typedef struct packed {
    mem_pkg::word_t data;
  } lut_rsp_t;

endpackage

// File: rtl/fpga_ram.sv
// ################################################
// Behavioral single-port RAM, no reset on contents
// Read of a word being written returns old data
// ################################################
`timescale 1ns/1ns

module fpga_ram #(
  parameter int DATA_W = 42,
  parameter int ADDR_W = 8
) (
  input  logic              CLK,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] din,
  input  logic              we,
  output logic [DATA_W-1:0] dout
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // Synchronous write
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
  end

  // Registered read every cycle
  always_ff @(posedge CLK) begin
    dout <= mem[addr];
  end

endmodule

// File: rtl/spsram_256x84.sv
// ################################################
// 256x84 SRAM, cen/gwen/half_wen all active low
// Only per-half write enables, no bit mask
// ################################################
`timescale 1ns/1ns

module spsram_256x84 (
  input  logic                CLK,
  input  logic                cen,
  input  logic                gwen,
  input  mem_pkg::half_mask_t half_wen,
  input  mem_pkg::addr_t      addr,
  input  mem_pkg::word_t      d,
  output mem_pkg::word_t      q
);

  localparam int HALF_W     = $bits(mem_pkg::half_t);
  localparam int ADDR_W     = $bits(mem_pkg::addr_t);
  localparam int NUM_HALVES = $bits(mem_pkg::half_mask_t);

  mem_pkg::addr_t      addr_hold;
  mem_pkg::addr_t      ram_addr;
  mem_pkg::half_mask_t ram_we;

  // Latch address on every enabled cycle
  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_hold <= addr;
    end
  end

  // Idle cycles keep reading the last address,
  // so q holds the last entry accessed
  assign ram_addr = cen ? addr_hold : addr;

  for (genvar i = 0; i < NUM_HALVES; i++) begin : g_half
    // Half written only with chip, global and own enable low
    assign ram_we[i] = !cen && !gwen && !half_wen[i];

    fpga_ram #(
      .DATA_W (HALF_W),
      .ADDR_W (ADDR_W)
    ) u_ram (
      .CLK  (CLK),
      .addr (ram_addr),
      .din  (d[i*HALF_W +: HALF_W]),
      .we   (ram_we[i]),
      .dout (q[i*HALF_W +: HALF_W])
    );
  end

endmodule

// File: rtl/req_ingress.sv
// ################################################
// Request queue, never overflows if client obeys
// credits; pop on an empty queue is not allowed
// ################################################
`timescale 1ns/1ns
`include "lut_config.svh"

module req_ingress (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               req_valid,
  input  link_pkg::lut_req_t req,
  output link_pkg::lut_req_t head,
  output logic               head_valid,
  input  logic               pop,
  output logic               req_credit
);

  localparam int PTR_W = $clog2(`LUT_REQ_DEPTH);

  // Entry storage
  link_pkg::lut_req_t queue [`LUT_REQ_DEPTH];

  // Pointers carry one wrap bit
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;

  // Every valid beat is stored, credits guarantee room
  always_ff @(posedge CLK) begin
    if (req_valid) begin
      queue[wr_ptr[PTR_W-1:0]] <= req;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      req_credit <= 1'b0;
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // One credit back per freed entry, a cycle later
      req_credit <= pop;
    end
  end

  // Head is the oldest entry, visible the cycle after the write
  assign head_valid = (wr_ptr != rd_ptr);
  assign head       = queue[rd_ptr[PTR_W-1:0]];

endmodule

// File: rtl/access_engine.sv
// ################################################
// Issues one request per cycle to the SRAM
// Reads need a reserved egress slot, writes don't
// ################################################
`timescale 1ns/1ns

module access_engine (
  input  logic                CLK,
  input  logic                rst_n,
  input  link_pkg::lut_req_t  head,
  input  logic                head_valid,
  output logic                pop,
  input  logic [2:0]          free_slots,
  output logic                cen,
  output logic                gwen,
  output mem_pkg::half_mask_t half_wen,
  output mem_pkg::addr_t      addr,
  output mem_pkg::word_t      d,
  input  mem_pkg::word_t      q,
  output logic                push,
  output link_pkg::lut_rsp_t  push_data
);

  // Read issued last cycle, its data is on q now
  logic rd_inflight;
  logic is_read;
  logic issue;

  assign is_read = (head.op == link_pkg::op_read);

  // A read in flight will take one free slot next cycle,
  // so a new read needs one more slot than that
  assign issue = head_valid &&
                 (!is_read || (free_slots > {2'b00, rd_inflight}));

  // Pop and SRAM access share the cycle
  assign pop = issue;

  // Active-low SRAM controls
  assign cen      = !issue;
  assign gwen     = !(issue && !is_read);
  // Mask set means write that half
  assign half_wen = ~head.mask;
  assign addr     = head.index;
  assign d        = head.data;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rd_inflight <= 1'b0;
    end else begin
      rd_inflight <= issue && is_read;
    end
  end

  // Forward read data the cycle q becomes valid
  assign push           = rd_inflight;
  assign push_data.data = q;

endmodule

// File: rtl/rsp_egress.sv
// ################################################
// Response buffer with a downstream credit count
// Client must never return more credits than used
// ################################################
`timescale 1ns/1ns
`include "lut_config.svh"

module rsp_egress (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               push,
  input  link_pkg::lut_rsp_t push_data,
  output logic [2:0]         free_slots,
  output logic               rsp_valid,
  output link_pkg::lut_rsp_t rsp,
  input  logic               rsp_credit
);

  localparam int PTR_W = $clog2(`LUT_RSP_DEPTH);
  localparam int CRD_W = $clog2(`LUT_RSP_CREDITS + 1);

  link_pkg::lut_rsp_t queue [`LUT_RSP_DEPTH];

  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic [PTR_W:0]   fill;
  logic [CRD_W-1:0] credits;
  logic             send;

  assign fill       = wr_ptr - rd_ptr;
  assign free_slots = 3'(`LUT_RSP_DEPTH) - 3'(fill);

  // Send oldest entry whenever a credit is held
  assign send = (fill != '0) && (credits != '0);

  // Engine only pushes into a reserved slot
  always_ff @(posedge CLK) begin
    if (push) begin
      queue[wr_ptr[PTR_W-1:0]] <= push_data;
    end
  end

  // Output register, meaningful only with rsp_valid
  always_ff @(posedge CLK) begin
    if (send) begin
      rsp <= queue[rd_ptr[PTR_W-1:0]];
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      credits   <= CRD_W'(`LUT_RSP_CREDITS);
      rsp_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Credit in and send in one cycle cancel out
      if (send && !rsp_credit) begin
        credits <= credits - 1'b1;
      end else if (!send && rsp_credit) begin
        credits <= credits + 1'b1;
      end
      rsp_valid <= send;
    end
  end

endmodule

// File: rtl/lut_top.sv
// ################################################
// Lookup table top, credit links on both sides
// Client starts with LUT_REQ_DEPTH request credits
// ################################################
`timescale 1ns/1ns

module lut_top (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               req_valid,
  input  link_pkg::lut_req_t req,
  output logic               req_credit,
  output logic               rsp_valid,
  output link_pkg::lut_rsp_t rsp,
  input  logic               rsp_credit
);

  // Ingress to engine
  link_pkg::lut_req_t  head;
  logic                head_valid;
  logic                pop;

  // Engine to SRAM
  logic                cen;
  logic                gwen;
  mem_pkg::half_mask_t half_wen;
  mem_pkg::addr_t      addr;
  mem_pkg::word_t      d;
  mem_pkg::word_t      q;

  // Engine to egress
  logic                push;
  link_pkg::lut_rsp_t  push_data;
  logic [2:0]          free_slots;

  req_ingress u_ingress (
    .CLK, .rst_n, .req_valid, .req, .head, .head_valid, .pop, .req_credit
  );

  access_engine u_engine (
    .CLK, .rst_n, .head, .head_valid, .pop, .free_slots,
    .cen, .gwen, .half_wen, .addr, .d, .q, .push, .push_data
  );

  spsram_256x84 u_sram (
    .CLK, .cen, .gwen, .half_wen, .addr, .d, .q
  );

  rsp_egress u_egress (
    .CLK, .rst_n, .push, .push_data, .free_slots, .rsp_valid, .rsp, .rsp_credit
  );

endmodule

// File: test/tb_lut_top.sv
// ################################################
// Client side obeys both credit links of lut_top
// Every response is checked against a per-half model
// ################################################
`timescale 1ns/1ns
`include "lut_config.svh"

module tb_lut_top;

  localparam int ENTRIES = 1 << `LUT_ADDR_W;
  localparam int TIMEOUT = 1000;

  logic               CLK;
  logic               rst_n;
  logic               req_valid;
  link_pkg::lut_req_t req;
  logic               req_credit;
  logic               rsp_valid;
  link_pkg::lut_rsp_t rsp;
  logic               rsp_credit;

  // Reference model and expected read data in order
  mem_pkg::word_t model [ENTRIES];
  mem_pkg::word_t exp_q [$];

  // Link bookkeeping
  int    reqs_sent;
  int    credits_returned;
  int    rsp_count;
  int    rsp_given;
  logic  credit_on;
  logic  credit_slow;
  string test_name;

  lut_top dut (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  // 4 ns clock
  always #2 CLK = ~CLK;

  task automatic report_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input mem_pkg::word_t expected,
                            input mem_pkg::word_t actual);
    $display("error %s: expected %0h actual %0h", name, expected, actual);
    report_failure();
  endtask

  task automatic fail_plain(input string what);
    $display("%s", what);
    report_failure();
  endtask

  // Link stays quiet through reset until the first request
  assert property (@(posedge CLK) (reqs_sent == 0) |-> (!rsp_valid && !req_credit))
    else fail_value(test_name, '0, mem_pkg::word_t'({rsp_valid, req_credit}));

  // Never more request credits back than requests sent
  assert property (@(posedge CLK) disable iff (!rst_n) credits_returned <= reqs_sent)
    else fail_value(test_name, mem_pkg::word_t'(reqs_sent),
                    mem_pkg::word_t'(credits_returned));

  // Each response must be covered by a downstream credit
  assert property (@(posedge CLK) disable iff (!rst_n)
                   rsp_valid |-> (rsp_count <= `LUT_RSP_CREDITS + rsp_given))
    else fail_value(test_name, mem_pkg::word_t'(`LUT_RSP_CREDITS + rsp_given),
                    mem_pkg::word_t'(rsp_count));

  function automatic mem_pkg::word_t rand_word();
    logic [95:0] raw;
    raw = {$urandom(), $urandom(), $urandom()};
    return raw[$bits(mem_pkg::word_t)-1:0];
  endfunction

  // Each half is written only when its mask bit is set
  function automatic void model_write(input mem_pkg::addr_t index, input mem_pkg::word_t data,
                                      input mem_pkg::half_mask_t mask);
    if (mask[0]) begin
      model[index][`LUT_HALF_W-1:0] = data[`LUT_HALF_W-1:0];
    end
    if (mask[1]) begin
      model[index][2*`LUT_HALF_W-1:`LUT_HALF_W] = data[2*`LUT_HALF_W-1:`LUT_HALF_W];
    end
  endfunction

  function automatic int credits_held();
    return `LUT_REQ_DEPTH + credits_returned - reqs_sent;
  endfunction

  function automatic bit drained();
    return exp_q.size() == 0 && credits_returned == reqs_sent && rsp_given == rsp_count;
  endfunction

  // Sends one request beat once a credit is in hand
  task automatic send_req(input link_pkg::op_e op, input mem_pkg::addr_t index,
                          input mem_pkg::word_t data, input mem_pkg::half_mask_t mask);
    int waited;
    waited = 0;
    while (credits_held() == 0 && waited < TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if (credits_held() == 0) begin
      fail_plain("timed out waiting for a request credit");
    end
    req_valid = 1'b1;
    req.op    = op;
    req.index = index;
    req.data  = data;
    req.mask  = mask;
    if (op == link_pkg::op_write) begin
      model_write(index, data, mask);
    end else begin
      exp_q.push_back(model[index]);
    end
    reqs_sent++;
    @(negedge CLK);
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!drained() && waited < TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if (!drained()) begin
      fail_plain("timed out waiting for the DUT to drain");
    end
  endtask

  // Responses and credits sampled on the falling edge
  always @(negedge CLK) begin : monitor
    mem_pkg::word_t expected;
    if (rst_n) begin
      if (req_credit) begin
        credits_returned++;
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          fail_plain("response arrived with no read outstanding");
        end
        expected = exp_q.pop_front();
        assert (rsp.data == expected) else fail_value(test_name, expected, rsp.data);
        rsp_count++;
      end
    end
  end

  // Downstream consumer returns one credit per response taken
  initial begin : consumer
    rsp_credit = 1'b0;
    rsp_given  = 0;
    forever begin
      @(negedge CLK);
      rsp_credit = 1'b0;
      if (rst_n && credit_on && rsp_given < rsp_count) begin
        // Slow mode holds credits back at random
        if (!credit_slow || ($urandom() % 4) == 0) begin
          rsp_credit = 1'b1;
          rsp_given++;
        end
      end
    end
  end

  initial begin : main
    int                  base;
    int                  waited;
    mem_pkg::addr_t      idx;
    mem_pkg::half_mask_t mask;
    link_pkg::op_e       op;
    void'($urandom(32'h3c7e_7957));
    CLK              = 1'b0;
    rst_n            = 1'b0;
    req_valid        = 1'b0;
    req              = '0;
    reqs_sent        = 0;
    credits_returned = 0;
    rsp_count        = 0;
    credit_on        = 1'b1;
    credit_slow      = 1'b0;
    test_name        = "reset_idle";
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    // Quiet link with no requests
    for (int i = 0; i < 10; i++) begin
      @(negedge CLK);
      assert (!rsp_valid && !req_credit)
        else fail_value(test_name, '0, mem_pkg::word_t'({rsp_valid, req_credit}));
    end

    test_name = "full_write_read";
    for (int i = 0; i < ENTRIES; i++) begin
      send_req(link_pkg::op_write, mem_pkg::addr_t'(i), rand_word(), 2'b11);
    end
    for (int i = 0; i < ENTRIES; i++) begin
      send_req(link_pkg::op_read, mem_pkg::addr_t'(i), '0, 2'b00);
    end
    wait_drain();

    // Alternate low and high half writes, each read right after
    test_name = "half_write";
    for (int i = 0; i < 64; i++) begin
      idx  = mem_pkg::addr_t'($urandom());
      mask = (i % 2 == 0) ? 2'b01 : 2'b10;
      send_req(link_pkg::op_write, idx, rand_word(), mask);
      send_req(link_pkg::op_read, idx, '0, 2'b00);
    end
    wait_drain();

    // Hold all downstream credits during 8 reads
    test_name = "rsp_backpressure";
    credit_on = 1'b0;
    base      = rsp_count;
    for (int i = 0; i < 8; i++) begin
      send_req(link_pkg::op_read, mem_pkg::addr_t'($urandom()), '0, 2'b00);
    end
    waited = 0;
    while (rsp_count < base + `LUT_RSP_CREDITS && waited < TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if (rsp_count < base + `LUT_RSP_CREDITS) begin
      fail_plain("responses stopped before the downstream credits ran out");
    end
    for (int i = 0; i < 20; i++) begin
      @(negedge CLK);
      assert (rsp_count == base + `LUT_RSP_CREDITS)
        else fail_value(test_name, mem_pkg::word_t'(base + `LUT_RSP_CREDITS),
                        mem_pkg::word_t'(rsp_count));
    end
    credit_on = 1'b1;
    wait_drain();

    // Random traffic with late credit returns
    test_name   = "random_mix";
    credit_slow = 1'b1;
    for (int i = 0; i < 300; i++) begin
      op   = (($urandom() % 2) == 0) ? link_pkg::op_read : link_pkg::op_write;
      idx  = mem_pkg::addr_t'($urandom());
      mask = mem_pkg::half_mask_t'($urandom());
      send_req(op, idx, rand_word(), mask);
      if (($urandom() % 4) == 0) begin
        @(negedge CLK);
      end
    end
    wait_drain();

    $display("Everything OK");
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/link_pkg.sv
rtl/fpga_ram.sv
rtl/spsram_256x84.sv
rtl/req_ingress.sv
rtl/access_engine.sv
rtl/rsp_egress.sv
rtl/lut_top.sv
test/tb_lut_top.sv

// File: run.sh
#!/bin/sh
# Build the lookup table testbench with Verilator and run it.
# The exit status of the simulation binary is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_lut_top \
  -f compile.f \
  -o tb_lut_top

./obj_dir/tb_lut_top
